//--- source/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Fetch address width, one byte-addressed 32-bit word
`define ICACHE_ADDR_W 32

// Associativity
`define ICACHE_WAYS 4

// Number of sets and the index width that selects one
`define ICACHE_SETS 16
`define ICACHE_IDX_W 4

// Instructions per line
`define ICACHE_LINE_WORDS 4

// Line offset in bytes: 2 word bits plus 2 byte bits
`define ICACHE_OFS_W 4

// Instruction width
`define ICACHE_INSTR_W 32

`endif

//--- source/icache_pkg.sv
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

  // Control step from the CU to the memory-control decoder
  typedef enum logic [1:0] {
    NoCtrl,
    ReadSet,
    WriteLineAndTag,
    InvalidSet
  } icache_ctrl_e;

  // Tag is whatever is left above index and offset
  typedef logic [`ICACHE_ADDR_W-`ICACHE_IDX_W-`ICACHE_OFS_W-1:0] icache_tag_t;

  // Field view of a fetch address
  typedef struct packed {
    icache_tag_t                tag;
    logic [`ICACHE_IDX_W-1:0]   idx;
    logic [`ICACHE_OFS_W-1:0]   ofs;
  } icache_addr_fields_t;

  // Same word seen raw or split into fields
  typedef union packed {
    logic [`ICACHE_ADDR_W-1:0]  raw;
    icache_addr_fields_t        f;
  } icache_addr_u;

  // Whole line, word 0 in the low bits
  typedef logic [`ICACHE_LINE_WORDS*`ICACHE_INSTR_W-1:0] icache_line_t;

  // One tag/valid entry
  typedef struct packed {
    logic        valid;
    icache_tag_t tag;
  } icache_tv_t;

  // One-hot way select
  typedef logic [`ICACHE_WAYS-1:0] icache_replace_vec_t;

endpackage

`default_nettype wire

//--- source/icache_mem_if.sv
`default_nettype none

`include "icache_settings.svh"

interface icache_mem_if;

  // Byte lanes of one data line
  localparam int BE_W = `ICACHE_LINE_WORDS * `ICACHE_INSTR_W / 8;

  // Data array strobes, one entry per way
  logic [`ICACHE_WAYS-1:0]           data_cs;
  logic [`ICACHE_WAYS-1:0]           data_we;
  logic [`ICACHE_WAYS-1:0][BE_W-1:0] data_be;

  // Tag/valid strobes; be bit 1 is the tag field, bit 0 the valid field
  logic [`ICACHE_WAYS-1:0]           tv_cs;
  logic [`ICACHE_WAYS-1:0]           tv_we;
  logic [`ICACHE_WAYS-1:0][1:0]      tv_be;

  modport ctrl (output data_cs, data_we, data_be, tv_cs, tv_we, tv_be);
  modport mem  (input  data_cs, data_we, data_be, tv_cs, tv_we, tv_be);

endinterface

`default_nettype wire

//--- source/icache_cfg_regs.sv
`default_nettype none

module icache_cfg_regs (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        cfg_we_i,
  input  logic [1:0]  cfg_wdata_i,
  input  logic        hit_i,
  input  logic        flush_done_i,
  output logic        cache_en_o,
  output logic        flush_start_o,
  output logic        flush_busy_o,
  output logic [15:0] hit_count_o
);

  // Start pulse comes straight from the write, ignored while a sweep runs
  assign flush_start_o = cfg_we_i & cfg_wdata_i[1] & ~flush_busy_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cache_en_o   <= 1'b0;
      flush_busy_o <= 1'b0;
      hit_count_o  <= '0;
    end else begin
      if (cfg_we_i) begin
        cache_en_o <= cfg_wdata_i[0];
      end
      // Busy from the cycle after the write to the last swept set
      if (flush_start_o) begin
        flush_busy_o <= 1'b1;
      end else if (flush_done_i) begin
        flush_busy_o <= 1'b0;
      end
      // Counter sticks at all ones
      if (hit_i && (hit_count_o != '1)) begin
        hit_count_o <= hit_count_o + 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/icache_cu.sv
`default_nettype none

`include "icache_settings.svh"

module icache_cu (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       fetch_req_i,
  input  icache_pkg::icache_addr_u   fetch_addr_i,
  input  logic                       cache_en_i,
  input  logic                       flush_start_i,
  input  logic                       hit_i,
  input  logic                       refill_valid_i,
  output icache_pkg::icache_ctrl_e   cond_ctrl_o,
  output logic                       mem_ctrl_en_o,
  output logic [`ICACHE_IDX_W-1:0]   set_idx_o,
  output logic                       refill_req_o,
  output logic [`ICACHE_ADDR_W-1:0]  refill_addr_o,
  output logic                       fetch_valid_o,
  output logic                       use_refill_o,
  output logic                       flush_done_o
);

  // WaitRefill serves a disabled cache, Write a miss being filled
  typedef enum logic [2:0] {
    Idle,
    Compare,
    WaitRefill,
    Write,
    Flush
  } cu_state_e;

  cu_state_e                state_q;
  cu_state_e                state_d;
  logic [`ICACHE_IDX_W-1:0] sweep_q;
  logic                     flush_pend_q;
  icache_pkg::icache_addr_u line_addr;

  // Next level always gets the line-aligned form of the held address
  always_comb begin
    line_addr       = fetch_addr_i;
    line_addr.f.ofs = '0;
    refill_addr_o   = line_addr.raw;
  end

  // Sweep counter owns the index during a flush
  assign set_idx_o    = (state_q == Flush) ? sweep_q : fetch_addr_i.f.idx;
  assign use_refill_o = (state_q == WaitRefill) || (state_q == Write);
  assign flush_done_o = (state_q == Flush) && (sweep_q == `ICACHE_IDX_W'(`ICACHE_SETS - 1));

  always_comb begin
    state_d       = state_q;
    cond_ctrl_o   = icache_pkg::NoCtrl;
    mem_ctrl_en_o = 1'b0;
    refill_req_o  = 1'b0;
    fetch_valid_o = 1'b0;
    case (state_q)
      Idle: begin
        // A pending flush goes before any fetch
        if (flush_pend_q || flush_start_i) begin
          state_d = Flush;
        end else if (fetch_req_i && cache_en_i) begin
          cond_ctrl_o   = icache_pkg::ReadSet;
          mem_ctrl_en_o = 1'b1;
          state_d       = Compare;
        end else if (fetch_req_i) begin
          refill_req_o = 1'b1;
          state_d      = WaitRefill;
        end
      end
      Compare: begin
        if (hit_i) begin
          fetch_valid_o = 1'b1;
          state_d       = Idle;
        end else begin
          // Keep the set open so the victim is picked from a fresh read
          cond_ctrl_o   = icache_pkg::ReadSet;
          mem_ctrl_en_o = 1'b1;
          refill_req_o  = 1'b1;
          state_d       = Write;
        end
      end
      WaitRefill: begin
        if (refill_valid_i) begin
          fetch_valid_o = 1'b1;
          state_d       = Idle;
        end
      end
      Write: begin
        mem_ctrl_en_o = 1'b1;
        if (refill_valid_i) begin
          // Fill the victim and hand the word over in the same cycle
          cond_ctrl_o   = icache_pkg::WriteLineAndTag;
          fetch_valid_o = 1'b1;
          state_d       = Idle;
        end else begin
          cond_ctrl_o = icache_pkg::ReadSet;
        end
      end
      Flush: begin
        cond_ctrl_o   = icache_pkg::InvalidSet;
        mem_ctrl_en_o = 1'b1;
        if (flush_done_o) begin
          state_d = Idle;
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= Idle;
      sweep_q      <= '0;
      flush_pend_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == Flush) begin
        sweep_q <= sweep_q + 1'b1;
      end
      // Remember a flush that arrives while a fetch is in flight
      if ((state_q == Idle) && (state_d == Flush)) begin
        flush_pend_q <= 1'b0;
      end else if (flush_start_i) begin
        flush_pend_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/icache_mem_ctrl.sv
`default_nettype none

`include "icache_settings.svh"

module icache_mem_ctrl (
  input  icache_pkg::icache_ctrl_e        cond_ctrl_i,
  input  logic                            mem_ctrl_en_i,
  input  icache_pkg::icache_replace_vec_t replace_vec_i,
  icache_mem_if.ctrl                      mem_ctrl_o
);

  always_comb begin
    // Nothing selected unless a step is enabled
    mem_ctrl_o.data_cs = '0;
    mem_ctrl_o.data_we = '0;
    mem_ctrl_o.data_be = '0;
    mem_ctrl_o.tv_cs   = '0;
    mem_ctrl_o.tv_we   = '0;
    mem_ctrl_o.tv_be   = '0;
    if (mem_ctrl_en_i) begin
      case (cond_ctrl_i)
        icache_pkg::ReadSet: begin
          // All ways of both arrays read together
          for (int k = 0; k < `ICACHE_WAYS; k++) begin
            mem_ctrl_o.data_cs[k] = 1'b1;
            mem_ctrl_o.data_be[k] = '1;
            mem_ctrl_o.tv_cs[k]   = 1'b1;
            mem_ctrl_o.tv_be[k]   = 2'b11;
          end
        end
        icache_pkg::WriteLineAndTag: begin
          // Only the victim way is selected
          for (int k = 0; k < `ICACHE_WAYS; k++) begin
            mem_ctrl_o.data_cs[k] = replace_vec_i[k];
            mem_ctrl_o.data_we[k] = 1'b1;
            mem_ctrl_o.data_be[k] = '1;
            mem_ctrl_o.tv_cs[k]   = replace_vec_i[k];
            mem_ctrl_o.tv_we[k]   = 1'b1;
            mem_ctrl_o.tv_be[k]   = 2'b11;
          end
        end
        icache_pkg::InvalidSet: begin
          // Valid field only; the tags stay untouched
          for (int k = 0; k < `ICACHE_WAYS; k++) begin
            mem_ctrl_o.tv_cs[k] = 1'b1;
            mem_ctrl_o.tv_we[k] = 1'b1;
            mem_ctrl_o.tv_be[k] = 2'b01;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/icache_replace.sv
`default_nettype none

`include "icache_settings.svh"

module icache_replace (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic [`ICACHE_WAYS-1:0]         valid_vec_i,
  input  logic                            refill_done_i,
  output icache_pkg::icache_replace_vec_t replace_vec_o
);

  localparam int PTR_W = $clog2(`ICACHE_WAYS);

  logic [PTR_W-1:0] rr_ptr_q;
  logic             found;

  // Lowest invalid way first, round-robin pointer on a full set
  always_comb begin
    replace_vec_o = '0;
    found         = 1'b0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (!valid_vec_i[w] && !found) begin
        replace_vec_o[w] = 1'b1;
        found            = 1'b1;
      end
    end
    if (!found) begin
      replace_vec_o[rr_ptr_q] = 1'b1;
    end
  end

  // Moves only when a valid line got evicted
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
    end else if (refill_done_i && (&valid_vec_i)) begin
      rr_ptr_q <= rr_ptr_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/icache_ssram.sv
`default_nettype none

`include "icache_settings.svh"

module icache_ssram (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  icache_mem_if.mem                 mem_i,
  input  logic [`ICACHE_IDX_W-1:0]  set_idx_i,
  input  icache_pkg::icache_tag_t   wr_tag_i,
  input  icache_pkg::icache_line_t  wr_line_i,
  output icache_pkg::icache_tv_t    rd_tv_o [`ICACHE_WAYS],
  output icache_pkg::icache_line_t  rd_line_o [`ICACHE_WAYS]
);

  localparam int BE_W = `ICACHE_LINE_WORDS * `ICACHE_INSTR_W / 8;

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    icache_pkg::icache_line_t data_mem [`ICACHE_SETS];
    icache_pkg::icache_tag_t  tag_mem  [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]  valid_mem;
    icache_pkg::icache_line_t rd_line_q;
    icache_pkg::icache_tag_t  rd_tag_q;
    logic                     rd_valid_q;

    // Data and tag storage with registered read
    always_ff @(posedge clk_i) begin
      if (mem_i.data_cs[w] && mem_i.data_we[w]) begin
        for (int b = 0; b < BE_W; b++) begin
          if (mem_i.data_be[w][b]) begin
            data_mem[set_idx_i][b*8 +: 8] <= wr_line_i[b*8 +: 8];
          end
        end
      end
      if (mem_i.data_cs[w] && !mem_i.data_we[w]) begin
        rd_line_q <= data_mem[set_idx_i];
      end
      if (mem_i.tv_cs[w] && mem_i.tv_we[w] && mem_i.tv_be[w][1]) begin
        tag_mem[set_idx_i] <= wr_tag_i;
      end
      if (mem_i.tv_cs[w] && !mem_i.tv_we[w]) begin
        rd_tag_q <= tag_mem[set_idx_i];
      end
    end

    // Valid bits, cleared on reset
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        valid_mem  <= '0;
        rd_valid_q <= 1'b0;
      end else begin
        // Writing the tag too marks the line valid, valid alone clears it
        if (mem_i.tv_cs[w] && mem_i.tv_we[w] && mem_i.tv_be[w][0]) begin
          valid_mem[set_idx_i] <= mem_i.tv_be[w][1];
        end
        // Read valid only shows in the cycle after a read
        rd_valid_q <= mem_i.tv_cs[w] & ~mem_i.tv_we[w] & valid_mem[set_idx_i];
      end
    end

    assign rd_tv_o[w]   = {rd_valid_q, rd_tag_q};
    assign rd_line_o[w] = rd_line_q;
  end

endmodule

`default_nettype wire

//--- source/icache_hit_logic.sv
`default_nettype none

`include "icache_settings.svh"

module icache_hit_logic (
  input  icache_pkg::icache_addr_u  fetch_addr_i,
  input  icache_pkg::icache_tv_t    rd_tv_i [`ICACHE_WAYS],
  input  icache_pkg::icache_line_t  rd_line_i [`ICACHE_WAYS],
  input  icache_pkg::icache_line_t  refill_line_i,
  input  logic                      use_refill_i,
  output logic                      hit_o,
  output logic [`ICACHE_WAYS-1:0]   valid_vec_o,
  output logic [`ICACHE_INSTR_W-1:0] fetch_instr_o
);

  logic [`ICACHE_WAYS-1:0]    hit_vec;
  icache_pkg::icache_line_t   sel_line;
  logic [`ICACHE_OFS_W-3:0]   word_sel;

  // Word index drops the two byte bits
  assign word_sel = fetch_addr_i.f.ofs[`ICACHE_OFS_W-1:2];

  always_comb begin
    sel_line = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      valid_vec_o[w] = rd_tv_i[w].valid;
      hit_vec[w]     = rd_tv_i[w].valid && (rd_tv_i[w].tag == fetch_addr_i.f.tag);
      // Hit vector is one-hot, so OR-ing the lines is a mux
      if (hit_vec[w]) begin
        sel_line = sel_line | rd_line_i[w];
      end
    end
    if (use_refill_i) begin
      sel_line = refill_line_i;
    end
  end

  assign hit_o         = |hit_vec;
  assign fetch_instr_o = sel_line[word_sel*`ICACHE_INSTR_W +: `ICACHE_INSTR_W];

endmodule

`default_nettype wire

//--- source/icache_top.sv
`default_nettype none

`include "icache_settings.svh"

module icache_top (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                                          fetch_req_i,
  input  logic [`ICACHE_ADDR_W-1:0]                     fetch_addr_i,
  output logic                                          fetch_valid_o,
  output logic [`ICACHE_INSTR_W-1:0]                    fetch_instr_o,
  output logic                                          refill_req_o,
  output logic [`ICACHE_ADDR_W-1:0]                     refill_addr_o,
  input  logic                                          refill_valid_i,
  input  logic [`ICACHE_LINE_WORDS*`ICACHE_INSTR_W-1:0] refill_line_i,
  input  logic                                          cfg_we_i,
  input  logic [1:0]                                    cfg_wdata_i,
  output logic                                          cache_en_o,
  output logic                                          flush_busy_o,
  output logic [15:0]                                   hit_count_o
);

  icache_pkg::icache_addr_u        fetch_addr;
  icache_pkg::icache_ctrl_e        cond_ctrl;
  icache_pkg::icache_replace_vec_t replace_vec;
  icache_pkg::icache_tv_t          rd_tv [`ICACHE_WAYS];
  icache_pkg::icache_line_t        rd_line [`ICACHE_WAYS];
  logic                            mem_ctrl_en;
  logic [`ICACHE_IDX_W-1:0]        set_idx;
  logic [`ICACHE_WAYS-1:0]         valid_vec;
  logic                            hit;
  logic                            use_refill;
  logic                            flush_start;
  logic                            flush_done;

  assign fetch_addr = fetch_addr_i;

  icache_mem_if mem_if ();

  icache_cfg_regs u_cfg_regs (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .hit_i         (hit),
    .flush_done_i  (flush_done),
    .cache_en_o    (cache_en_o),
    .flush_start_o (flush_start),
    .flush_busy_o  (flush_busy_o),
    .hit_count_o   (hit_count_o)
  );

  icache_cu u_cu (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr),
    .cache_en_i     (cache_en_o),
    .flush_start_i  (flush_start),
    .hit_i          (hit),
    .refill_valid_i (refill_valid_i),
    .cond_ctrl_o    (cond_ctrl),
    .mem_ctrl_en_o  (mem_ctrl_en),
    .set_idx_o      (set_idx),
    .refill_req_o   (refill_req_o),
    .refill_addr_o  (refill_addr_o),
    .fetch_valid_o  (fetch_valid_o),
    .use_refill_o   (use_refill),
    .flush_done_o   (flush_done)
  );

  icache_mem_ctrl u_mem_ctrl (
    .cond_ctrl_i   (cond_ctrl),
    .mem_ctrl_en_i (mem_ctrl_en),
    .replace_vec_i (replace_vec),
    .mem_ctrl_o    (mem_if.ctrl)
  );

  // Refill strobe doubles as the eviction event for the pointer
  icache_replace u_replace (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .valid_vec_i   (valid_vec),
    .refill_done_i (refill_valid_i),
    .replace_vec_o (replace_vec)
  );

  icache_ssram u_ssram (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .mem_i     (mem_if.mem),
    .set_idx_i (set_idx),
    .wr_tag_i  (fetch_addr.f.tag),
    .wr_line_i (refill_line_i),
    .rd_tv_o   (rd_tv),
    .rd_line_o (rd_line)
  );

  icache_hit_logic u_hit_logic (
    .fetch_addr_i  (fetch_addr),
    .rd_tv_i       (rd_tv),
    .rd_line_i     (rd_line),
    .refill_line_i (refill_line_i),
    .use_refill_i  (use_refill),
    .hit_o         (hit),
    .valid_vec_o   (valid_vec),
    .fetch_instr_o (fetch_instr_o)
  );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock, first rising edge half a period in
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2);
      clk_o = ~clk_o;
    end
  end

  // Reset released just after the last reset edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/tb_icache.sv
`default_nettype none

`include "icache_settings.svh"

module tb_icache;

  localparam int CLK_PERIOD = 40;
  localparam int TAG_LSB    = `ICACHE_OFS_W + `ICACHE_IDX_W;
  localparam int TAG_W      = `ICACHE_ADDR_W - TAG_LSB;
  localparam int LINE_W     = `ICACHE_LINE_WORDS * `ICACHE_INSTR_W;
  // Basic 8, same set 10, after flush 9, disabled 4 plus 1 after re-enable
  localparam int DIRECTED_FETCHES = 32;
  localparam int RAND_FETCHES     = 40;
  localparam int FLUSH_CYCLES     = `ICACHE_SETS + 4;
  localparam int WATCHDOG_CYCLES  =
    (DIRECTED_FETCHES + RAND_FETCHES) * 12 + FLUSH_CYCLES + 100;

  logic                       clk;
  logic                       rst_n;
  logic                       fetch_req;
  logic [`ICACHE_ADDR_W-1:0]  fetch_addr;
  logic                       fetch_valid;
  logic [`ICACHE_INSTR_W-1:0] fetch_instr;
  logic                       refill_req;
  logic [`ICACHE_ADDR_W-1:0]  refill_addr;
  logic                       refill_valid;
  logic [LINE_W-1:0]          refill_line;
  logic                       cfg_we;
  logic [1:0]                 cfg_wdata;
  logic                       cache_en;
  logic                       flush_busy;
  logic [15:0]                hit_count;

  // Reference model of the tag store, one round-robin pointer for all sets
  logic [TAG_W-1:0] model_tag [`ICACHE_SETS][`ICACHE_WAYS];
  logic             model_valid [`ICACHE_SETS][`ICACHE_WAYS];
  int               model_rr;
  logic             model_en;
  logic [15:0]      model_hits;
  logic             exp_hit;
  logic             exp_busy;
  logic [31:0]      exp_instr;
  logic [31:0]      exp_line_addr;
  logic             req_q = 1'b0;
  logic             cmp_cyc = 1'b0;
  int               refill_cnt = 0;
  int               seed = 32'hbc09_2225;

  tb_clock_gen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (2)
  ) clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  icache_top DUT (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .fetch_req_i    (fetch_req),
    .fetch_addr_i   (fetch_addr),
    .fetch_valid_o  (fetch_valid),
    .fetch_instr_o  (fetch_instr),
    .refill_req_o   (refill_req),
    .refill_addr_o  (refill_addr),
    .refill_valid_i (refill_valid),
    .refill_line_i  (refill_line),
    .cfg_we_i       (cfg_we),
    .cfg_wdata_i    (cfg_wdata),
    .cache_en_o     (cache_en),
    .flush_busy_o   (flush_busy),
    .hit_count_o    (hit_count)
  );

  // Next-level memory content: byte address of the word xor a constant
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [LINE_W-1:0] make_line(input logic [31:0] base);
    logic [LINE_W-1:0] line;
    for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
      line[i*32 +: 32] = mem_word(base + 32'(i * 4));
    end
    return line;
  endfunction

  function automatic logic predict_hit(input logic [31:0] addr);
    int   idx;
    logic hit;
    idx = int'(addr[`ICACHE_OFS_W +: `ICACHE_IDX_W]);
    hit = 1'b0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (model_valid[idx][w] && (model_tag[idx][w] == addr[31:TAG_LSB])) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Victim is the lowest invalid way, else the pointer, which then moves on
  task automatic install_line(input logic [31:0] addr);
    int idx;
    int victim;
    idx    = int'(addr[`ICACHE_OFS_W +: `ICACHE_IDX_W]);
    victim = -1;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!model_valid[idx][w]) begin
        victim = w;
      end
    end
    if (victim < 0) begin
      victim   = model_rr;
      model_rr = (model_rr + 1) % `ICACHE_WAYS;
    end
    model_tag[idx][victim]   = addr[31:TAG_LSB];
    model_valid[idx][victim] = 1'b1;
  endtask

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    stop_with_failure($sformatf("[ERROR] %0t %s expected %h actual %h",
                                $time, name, exp_val, act_val));
  endtask

  task automatic write_cfg(input logic [1:0] data);
    cfg_we    = 1'b1;
    cfg_wdata = data;
    @(posedge clk);
    #2;
    cfg_we   = 1'b0;
    model_en = data[0];
  endtask

  // Busy expected from the cycle after the write for one sweep
  task automatic flush_cache();
    write_cfg({1'b1, model_en});
    exp_busy = 1'b1;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        model_valid[s][w] = 1'b0;
      end
    end
    repeat (`ICACHE_SETS) @(posedge clk);
    #2;
    exp_busy = 1'b0;
    @(posedge clk);
    #2;
  endtask

  // One fetch, held until the word comes back, then one idle cycle
  task automatic fetch_word(input logic [31:0] addr);
    int start_cnt;
    int want;
    start_cnt  = refill_cnt;
    exp_hit    = model_en && predict_hit(addr);
    want       = exp_hit ? 0 : 1;
    fetch_addr = addr;
    fetch_req  = 1'b1;
    do begin
      @(negedge clk);
    end while (!fetch_valid);
    @(posedge clk);
    #2;
    fetch_req = 1'b0;
    assert (refill_cnt - start_cnt == want)
      else report_mismatch("refill_req_o pulses", 32'(want), 32'(refill_cnt - start_cnt));
    if (exp_hit) begin
      model_hits = model_hits + 16'd1;
    end else if (model_en) begin
      install_line(addr);
    end
    @(posedge clk);
    #2;
  endtask

  // First cycle after a new request is the compare cycle
  always @(posedge clk) begin
    req_q   <= fetch_req;
    cmp_cyc <= fetch_req & ~req_q;
  end

  always @(negedge clk) begin
    if (refill_req) begin
      refill_cnt <= refill_cnt + 1;
    end
  end

  assign exp_instr     = mem_word(fetch_addr);
  assign exp_line_addr = {fetch_addr[31:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}};

  instr_check: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid |-> (fetch_instr == exp_instr))
    else report_mismatch("fetch_instr_o", $sampled(exp_instr), $sampled(fetch_instr));

  hit_latency_check: assert property (@(posedge clk) disable iff (!rst_n)
    (cmp_cyc && exp_hit) |-> fetch_valid)
    else report_mismatch("fetch_valid_o", 32'd1, 32'($sampled(fetch_valid)));

  miss_refill_check: assert property (@(posedge clk) disable iff (!rst_n)
    (cmp_cyc && model_en && !exp_hit) |-> (refill_req && !fetch_valid))
    else report_mismatch("refill_req_o", 32'd1, 32'($sampled(refill_req)));

  refill_addr_check: assert property (@(posedge clk) disable iff (!rst_n)
    refill_req |-> (refill_addr == exp_line_addr))
    else report_mismatch("refill_addr_o", $sampled(exp_line_addr), $sampled(refill_addr));

  hit_count_check: assert property (@(posedge clk) disable iff (!rst_n)
    hit_count == model_hits)
    else report_mismatch("hit_count_o", 32'($sampled(model_hits)), 32'($sampled(hit_count)));

  flush_busy_check: assert property (@(posedge clk) disable iff (!rst_n)
    flush_busy == exp_busy)
    else report_mismatch("flush_busy_o", 32'($sampled(exp_busy)), 32'($sampled(flush_busy)));

  cache_en_check: assert property (@(posedge clk) disable iff (!rst_n)
    cache_en == model_en)
    else report_mismatch("cache_en_o", 32'($sampled(model_en)), 32'($sampled(cache_en)));

  // Next level answers each refill after 1 to 8 cycles
  initial begin : next_level
    int          delay;
    logic [31:0] base;
    refill_valid = 1'b0;
    refill_line  = '0;
    forever begin
      @(negedge clk);
      if (refill_req) begin
        delay = 1 + int'($unsigned($random(seed)) % 8);
        base  = refill_addr;
        repeat (delay) @(posedge clk);
        #2;
        refill_valid = 1'b1;
        refill_line  = make_line(base);
        @(posedge clk);
        #2;
        refill_valid = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    stop_with_failure("Timeout: the fetch sequence did not finish in time");
  end

  initial begin : stimulus
    logic [31:0] rnd;
    fetch_req  = 1'b0;
    fetch_addr = '0;
    cfg_we     = 1'b0;
    cfg_wdata  = '0;
    model_en   = 1'b0;
    model_hits = '0;
    model_rr   = 0;
    exp_hit    = 1'b0;
    exp_busy   = 1'b0;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        model_valid[s][w] = 1'b0;
        model_tag[s][w]   = '0;
      end
    end
    @(posedge rst_n);
    @(posedge clk);
    #2;
    write_cfg(2'b01);
    // Four lines in sets 0 to 3, then a different word of each
    for (int k = 0; k < 4; k++) begin
      fetch_word(32'h0000_1000 + 32'(k * 16));
    end
    for (int k = 0; k < 4; k++) begin
      fetch_word(32'h0000_1000 + 32'(k * 20));
    end
    // Five tags into set 5 force an eviction
    for (int k = 0; k < 5; k++) begin
      fetch_word(32'h0001_0050 + 32'(k * 256));
    end
    for (int k = 4; k >= 0; k--) begin
      fetch_word(32'h0001_0054 + 32'(k * 256));
    end
    // Everything resident misses again after the sweep
    flush_cache();
    for (int k = 0; k < 4; k++) begin
      fetch_word(32'h0000_1000 + 32'(k * 16));
    end
    for (int k = 0; k < 5; k++) begin
      fetch_word(32'h0001_0050 + 32'(k * 256));
    end
    // Disabled cache goes to the next level even for resident lines
    write_cfg(2'b00);
    fetch_word(32'h0000_1000);
    fetch_word(32'h0000_1014);
    fetch_word(32'h0000_3040);
    fetch_word(32'h0000_3058);
    write_cfg(2'b01);
    // Line fetched while disabled was never stored
    fetch_word(32'h0000_3040);
    // Small address pool, eight tags over all sets
    for (int n = 0; n < RAND_FETCHES; n++) begin
      rnd = $random(seed);
      fetch_word(32'h0001_0000 | (rnd & 32'h0000_07fc));
    end
    repeat (2) @(posedge clk);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
source/icache_pkg.sv
source/icache_mem_if.sv
source/icache_cfg_regs.sv
source/icache_cu.sv
source/icache_mem_ctrl.sv
source/icache_replace.sv
source/icache_ssram.sv
source/icache_hit_logic.sv
source/icache_top.sv
verification/tb_clock_gen.sv
verification/tb_icache.sv

//--- Makefile
BUILD_DIR = build

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator from verilog.f and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f verilog.f --top-module tb_icache \
		--Mdir $(BUILD_DIR) -o sim
	@out="$$(./$(BUILD_DIR)/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(BUILD_DIR)
